// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // data path width
  localparam int xlen = 32;

  // register index width, x0..x31
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;

  // major opcodes handled by this slice
  localparam logic [6:0] opc_op_imm = 7'b00_100_11;
  localparam logic [6:0] opc_op     = 7'b01_100_11;
  localparam logic [6:0] opc_lui    = 7'b01_101_11;
  localparam logic [6:0] opc_auipc  = 7'b00_101_11;

  // funct7 values that RV32I accepts for OP and the shift immediates
  localparam logic [6:0] funct7_base = 7'b00000_00;
  localparam logic [6:0] funct7_alt  = 7'b01000_00;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    op1_reg,
    op1_pc,
    op1_zero
  } op1_sel_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
  } fetch_s;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    alu_op_e               alu_op;
    op1_sel_e              op1_sel;
    logic                  op2_is_imm;
    logic [xlen-1:0]       op_a;
    logic [xlen-1:0]       op_b;
    logic [xlen-1:0]       imm;
    logic                  wen;
    logic                  illegal;
  } uop_s;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;
    logic                  wen;
    logic                  illegal;
  } retire_s;

endpackage

`default_nettype wire

// File: src/decode_ctrl.sv
`default_nettype none

module decode_ctrl import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  inst_valid,
  input  fetch_s                inst,
  input  logic                  ex_valid,
  input  uop_s                  ex_uop,
  input  logic [xlen-1:0]       ex_result,
  input  logic                  ret_valid,
  input  retire_s               ret,
  input  logic                  retire_ready,
  input  logic [xlen-1:0]       rdata1,
  input  logic [xlen-1:0]       rdata2,
  input  logic [xlen-1:0]       imm,
  output logic                  inst_ready,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [xlen-1:0]       raw_inst,
  output logic                  dec_valid,
  output uop_s                  dec_uop,
  output logic                  advance
);

  fetch_s inst_q;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic is_op_imm;
  logic is_op;
  logic is_lui;
  logic is_auipc;
  logic f7_base;
  logic f7_alt;
  logic legal;
  alu_op_e base_op;
  alu_op_e alu_op;

  // youngest in-flight producer wins, x0 never forwards
  function automatic logic [xlen-1:0] fwd_operand(
    input logic [reg_addr_w-1:0] src,
    input logic [xlen-1:0]       rf_value
  );
    logic [xlen-1:0] value;
    value = rf_value;
    if (src != '0) begin
      if (ex_valid && ex_uop.wen && ex_uop.rd == src) begin
        value = ex_result;
      end else if (ret_valid && ret.wen && ret.rd == src) begin
        value = ret.result;
      end
    end
    return value;
  endfunction

  // the whole pipe moves unless the retire stage is full and blocked
  assign advance = !ret_valid || retire_ready;
  // an empty decode stage can always take a new instruction
  assign inst_ready = advance || !dec_valid;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      dec_valid <= 1'b0;
    end else if (inst_ready) begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (inst_ready && inst_valid) begin
      inst_q <= inst;
    end
  end

  assign raw_inst = inst_q.inst;
  assign opcode = inst_q.inst[6:0];
  assign funct3 = inst_q.inst[14:12];
  assign funct7 = inst_q.inst[31:25];
  assign rs1 = inst_q.inst[19:15];
  assign rs2 = inst_q.inst[24:20];

  assign is_op_imm = opcode == opc_op_imm;
  assign is_op = opcode == opc_op;
  assign is_lui = opcode == opc_lui;
  assign is_auipc = opcode == opc_auipc;
  assign f7_base = funct7 == funct7_base;
  assign f7_alt = funct7 == funct7_alt;

  always_comb begin
    case (funct3)
      3'b000: base_op = (is_op && f7_alt) ? alu_sub : alu_add;
      3'b001: base_op = alu_sll;
      3'b010: base_op = alu_slt;
      3'b011: base_op = alu_sltu;
      3'b100: base_op = alu_xor;
      3'b101: base_op = f7_alt ? alu_sra : alu_srl;
      3'b110: base_op = alu_or;
      default: base_op = alu_and;
    endcase
  end

  // funct7 only matters for shifts on OP-IMM, but for every OP encoding
  always_comb begin
    legal = 1'b0;
    if (is_lui || is_auipc) begin
      legal = 1'b1;
    end else if (is_op_imm) begin
      case (funct3)
        3'b001: legal = f7_base;
        3'b101: legal = f7_base || f7_alt;
        default: legal = 1'b1;
      endcase
    end else if (is_op) begin
      if (funct3 == 3'b000 || funct3 == 3'b101) begin
        legal = f7_base || f7_alt;
      end else begin
        legal = f7_base;
      end
    end
  end

  // illegal ops pass a zero immediate, so they retire with result 0
  always_comb begin
    if (!legal) begin
      alu_op = alu_pass_b;
    end else if (is_lui || is_auipc) begin
      alu_op = alu_add;
    end else begin
      alu_op = base_op;
    end
  end

  always_comb begin
    dec_uop.pc = inst_q.pc;
    dec_uop.rd = inst_q.inst[11:7];
    dec_uop.alu_op = alu_op;
    if (is_auipc && legal) begin
      dec_uop.op1_sel = op1_pc;
    end else if (is_op_imm || is_op) begin
      dec_uop.op1_sel = legal ? op1_reg : op1_zero;
    end else begin
      dec_uop.op1_sel = op1_zero;
    end
    dec_uop.op2_is_imm = !(is_op && legal);
    dec_uop.op_a = fwd_operand(rs1, rdata1);
    dec_uop.op_b = fwd_operand(rs2, rdata2);
    dec_uop.imm = legal ? imm : '0;
    dec_uop.wen = legal;
    dec_uop.illegal = !legal;
  end

endmodule

`default_nettype wire

// File: src/imm_gen.sv
`default_nettype none

module imm_gen import rv_pkg::*; (
  input  logic [xlen-1:0] raw_inst,
  output logic [xlen-1:0] imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic is_shift;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] shamt_imm;
  logic [xlen-1:0] u_imm;

  assign opcode = raw_inst[6:0];
  assign funct3 = raw_inst[14:12];

  // slli, srli and srai carry a 5-bit shift amount in place of imm[4:0]
  assign is_shift = funct3 == 3'b001 || funct3 == 3'b101;

  assign i_imm = {{20{raw_inst[31]}}, raw_inst[31:20]};
  assign shamt_imm = {27'd0, raw_inst[24:20]};
  assign u_imm = {raw_inst[31:12], 12'd0};

  always_comb begin
    case (opcode)
      opc_op_imm: imm = is_shift ? shamt_imm : i_imm;
      opc_lui, opc_auipc: imm = u_imm;
      // R-type and everything unsupported
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file import rv_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2,
  input  logic                  wen,
  input  logic [reg_addr_w-1:0] waddr,
  input  logic [xlen-1:0]       wdata
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:num_regs-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // no write-to-read bypass here, the retire stage forwards instead
  always_comb begin
    if (rs1 == '0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[rs1];
    end
    if (rs2 == '0) begin
      rdata2 = '0;
    end else begin
      rdata2 = regs[rs2];
    end
  end

endmodule

`default_nettype wire

// File: src/alu.sv
`default_nettype none

module alu import rv_pkg::*; (
  input  uop_s            uop,
  output logic [xlen-1:0] result
);

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [4:0] shamt;

  always_comb begin
    case (uop.op1_sel)
      op1_reg: op1 = uop.op_a;
      op1_pc: op1 = uop.pc;
      default: op1 = '0;
    endcase
  end

  assign op2 = uop.op2_is_imm ? uop.imm : uop.op_b;
  assign shamt = op2[4:0];

  always_comb begin
    case (uop.alu_op)
      alu_add: result = op1 + op2;
      alu_sub: result = op1 - op2;
      alu_sll: result = op1 << shamt;
      alu_slt: begin
        result = {31'd0, $signed(op1) < $signed(op2)};
      end
      alu_sltu: result = {31'd0, op1 < op2};
      alu_xor: result = op1 ^ op2;
      alu_srl: result = op1 >> shamt;
      // arithmetic shift keeps the sign bit
      alu_sra: result = $unsigned($signed(op1) >>> shamt);
      alu_or: result = op1 | op2;
      alu_and: result = op1 & op2;
      alu_pass_b: result = op2;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/pipe_reg.sv
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     load,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // flush beats load, so nothing in flight survives it
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: src/int_core.sv
`default_nettype none

module int_core import rv_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    flush,
  input  logic    inst_valid,
  output logic    inst_ready,
  input  fetch_s  inst,
  output logic    retire_valid,
  input  logic    retire_ready,
  output retire_s retire
);

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic [xlen-1:0] raw_inst;
  logic [xlen-1:0] imm;
  logic dec_valid;
  uop_s dec_uop;
  logic advance;
  logic ex_valid;
  uop_s ex_uop;
  logic [xlen-1:0] ex_result;
  retire_s ex_retire;
  logic rf_wen;

  decode_ctrl u_decode_ctrl (
    .clock(clock), .reset(reset), .flush(flush),
    .inst_valid(inst_valid), .inst(inst),
    .ex_valid(ex_valid), .ex_uop(ex_uop), .ex_result(ex_result),
    .ret_valid(retire_valid), .ret(retire), .retire_ready(retire_ready),
    .rdata1(rdata1), .rdata2(rdata2), .imm(imm),
    .inst_ready(inst_ready), .rs1(rs1), .rs2(rs2), .raw_inst(raw_inst),
    .dec_valid(dec_valid), .dec_uop(dec_uop), .advance(advance)
  );

  imm_gen u_imm_gen (.raw_inst(raw_inst), .imm(imm));

  // architectural write happens on the retire handshake
  assign rf_wen = retire_valid && retire_ready && retire.wen;

  reg_file u_reg_file (
    .clock(clock), .reset(reset), .rs1(rs1), .rs2(rs2),
    .rdata1(rdata1), .rdata2(rdata2),
    .wen(rf_wen), .waddr(retire.rd), .wdata(retire.result)
  );

  pipe_reg #(.payload_t(uop_s)) ex_stage (
    .clock(clock), .reset(reset), .flush(flush), .load(advance),
    .in_valid(dec_valid), .in_data(dec_uop),
    .out_valid(ex_valid), .out_data(ex_uop)
  );

  alu u_alu (.uop(ex_uop), .result(ex_result));

  assign ex_retire = '{pc: ex_uop.pc, rd: ex_uop.rd, result: ex_result,
                       wen: ex_uop.wen, illegal: ex_uop.illegal};

  pipe_reg #(.payload_t(retire_s)) ret_stage (
    .clock(clock), .reset(reset), .flush(flush), .load(advance),
    .in_valid(ex_valid), .in_data(ex_retire),
    .out_valid(retire_valid), .out_data(retire)
  );

endmodule

`default_nettype wire

// File: tests/int_core_props.sv
`default_nettype none

module int_core_props import rv_pkg::*; (
  input logic    clock,
  input logic    reset,
  input logic    flush,
  input logic    inst_valid,
  input logic    inst_ready,
  input logic    retire_valid,
  input logic    retire_ready,
  input retire_s retire
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;
  logic accept_seen;
  logic accept_old;

  // set by an accept since the last reset or flush
  // accept_old trails it by one edge
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      accept_seen <= 1'b0;
      accept_old <= 1'b0;
    end else begin
      accept_seen <= accept_seen || (inst_valid && inst_ready);
      accept_old <= accept_seen;
    end
  end

  retire_held: assert property (@(posedge clock) disable iff (reset)
    retire_valid && !retire_ready |=> $stable(retire))
  else begin
    failures++;
    $error("retire payload changed while the retire port was stalled");
  end

  retire_cleared: assert property (@(posedge clock)
    (reset || flush) |=> !retire_valid)
  else begin
    failures++;
    $error("retire_valid high in the cycle after reset or flush");
  end

  retire_after_accept: assert property (@(posedge clock) disable iff (reset)
    retire_valid |-> $past(accept_old))
  else begin
    failures++;
    $error("retire_valid raised without an accept two or more cycles earlier");
  end

endmodule

bind int_core int_core_props props0 (.*);

`default_nettype wire

// File: tests/int_core_tb.sv
`default_nettype none

module int_core_tb import rv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int accept_timeout = 200;
  localparam int drain_timeout = 100;
  localparam int watchdog_cycles = 20000;

  // one accepted instruction waiting to retire
  typedef struct packed {
    fetch_s      fetch;
    logic [31:0] cycle;
    logic        timed;
  } pending_s;

  logic clock;
  logic reset;
  logic flush;
  logic inst_valid;
  logic inst_ready;
  fetch_s inst;
  logic retire_valid;
  logic retire_ready;
  retire_s retire;

  logic [31:0] lfsr_state;
  logic [31:0] model_regs [0:31];
  pending_s pending [$];
  logic [31:0] next_pc;
  logic [31:0] cycle_count;
  logic in_fire;
  logic timing_mode;
  int retired;
  int mismatches;
  int other_errors;
  int assertion_failures;

  int_core dut0 (
    .clock(clock), .reset(reset), .flush(flush),
    .inst_valid(inst_valid), .inst_ready(inst_ready), .inst(inst),
    .retire_valid(retire_valid), .retire_ready(retire_ready), .retire(retire)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  // registers stay within x0..x7 so hazards are frequent
  function automatic logic [31:0] build_inst();
    logic [31:0] r;
    logic [2:0] kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] opcode;
    logic [31:0] word;
    r = take_bits(3);
    kind = r[2:0];
    r = take_bits(9);
    rd = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    r = take_bits(4);
    f3 = r[2:0];
    f7 = r[3] ? 7'b0100000 : 7'b0000000;
    case (kind)
      3'd0, 3'd1, 3'd2: begin
        r = take_bits(12);
        if (f3 == 3'b001 || f3 == 3'b101) begin
          word = {f7, rs2, rs1, f3, rd, opc_op_imm};
        end else begin
          word = {r[11:0], rs1, f3, rd, opc_op_imm};
        end
      end
      3'd3, 3'd4: word = {f7, rs2, rs1, f3, rd, opc_op};
      3'd5: begin
        r = take_bits(21);
        word = {r[19:0], rd, r[20] ? opc_lui : opc_auipc};
      end
      3'd6: begin
        // funct7 bit 0 set is never legal, OP-IMM needs a shift funct3 for it to count
        r = take_bits(6);
        if (f3[1]) begin
          word = {r[5:0], 1'b1, rs2, rs1, f3, rd, opc_op};
        end else begin
          word = {r[5:0], 1'b1, rs2, rs1, f3[2], 2'b01, rd, opc_op_imm};
        end
      end
      default: begin
        r = take_bits(32);
        opcode = r[6:0];
        if (opcode == opc_op || opcode == opc_op_imm || opcode == opc_lui ||
            opcode == opc_auipc) begin
          opcode = 7'b0000011;
        end
        word = {r[31:12], rd, opcode};
      end
    endcase
    return word;
  endfunction

  // reference result from the RV32I rules and the model registers
  function automatic retire_s expected_retire(input fetch_s f);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic is_reg_op;
    logic f7_zero;
    logic [31:0] a;
    logic [31:0] op2;
    logic [4:0] shamt;
    logic ok;
    logic [31:0] value;
    retire_s r;
    opcode = f.inst[6:0];
    f3 = f.inst[14:12];
    f7 = f.inst[31:25];
    is_reg_op = opcode == opc_op;
    f7_zero = f7 == 7'b0000000;
    a = model_regs[f.inst[19:15]];
    op2 = is_reg_op ? model_regs[f.inst[24:20]] : {{20{f.inst[31]}}, f.inst[31:20]};
    shamt = op2[4:0];
    value = '0;
    if (opcode == opc_lui) begin
      ok = 1'b1;
      value = {f.inst[31:12], 12'd0};
    end else if (opcode == opc_auipc) begin
      ok = 1'b1;
      value = f.pc + {f.inst[31:12], 12'd0};
    end else if (is_reg_op || opcode == opc_op_imm) begin
      // funct7 must be zero on OP unless the op has an alternate form
      ok = !is_reg_op || f7_zero;
      case (f3)
        3'b000: begin
          ok = !is_reg_op || f7_zero || f7 == 7'b0100000;
          value = (is_reg_op && !f7_zero) ? a - op2 : a + op2;
        end
        3'b001: begin
          ok = f7_zero;
          value = a << shamt;
        end
        3'b101: begin
          ok = f7_zero || f7 == 7'b0100000;
          value = f7_zero ? a >> shamt : $unsigned($signed(a) >>> shamt);
        end
        3'b010: value = {31'd0, $signed(a) < $signed(op2)};
        3'b011: value = {31'd0, a < op2};
        3'b100: value = a ^ op2;
        3'b110: value = a | op2;
        default: value = a & op2;
      endcase
    end else begin
      ok = 1'b0;
    end
    // illegal ones come back with a zero result and no write
    if (!ok) begin
      value = '0;
    end
    r = '{pc: f.pc, rd: f.inst[11:7], result: value, wen: ok, illegal: !ok};
    return r;
  endfunction

  task automatic check_retire(input string name, input retire_s actual,
                              input retire_s expected);
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %p expected %p", $time, name, actual, expected);
    end
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] actual,
                            input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic take_retire();
    pending_s entry;
    retire_s expected;
    logic [31:0] age;
    if (pending.size() == 0) begin
      other_errors++;
      $display("ERROR at %0t: retire transfer with no instruction outstanding", $time);
    end else begin
      entry = pending.pop_front();
      expected = expected_retire(entry.fetch);
      age = cycle_count - entry.cycle;
      check_retire("retire", retire, expected);
      // visible after accept edge + 2, so the transfer lands on edge + 3
      if (entry.timed) begin
        check_word("retire_latency", age, 32'd3);
      end else if (age < 32'd3) begin
        other_errors++;
        $display("ERROR at %0t: instruction retired %0d cycles after accept", $time, age);
      end
      if (!expected.illegal && expected.rd != '0) begin
        model_regs[expected.rd] = expected.result;
      end
      retired++;
    end
  endtask

  // handshakes are sampled mid-cycle where inputs and outputs are settled
  always @(negedge clock) begin
    if (reset !== 1'b0) begin
      in_fire = 1'b0;
    end else begin
      cycle_count = cycle_count + 32'd1;
      in_fire = inst_valid && inst_ready;
      if (retire_valid && retire_ready) begin
        take_retire();
      end
      if (flush) begin
        pending.delete();
      end else if (in_fire) begin
        pending.push_back('{fetch: inst, cycle: cycle_count, timed: timing_mode});
      end
    end
  end

  task automatic issue_stream(input int count, input logic stall_retire,
                              input logic use_flush);
    int sent;
    int waited;
    logic [31:0] r;
    sent = 0;
    waited = 0;
    while (sent < count && waited <= accept_timeout) begin
      @(posedge clock);
      #1;
      flush = 1'b0;
      if (in_fire) begin
        inst_valid = 1'b0;
        sent++;
        waited = 0;
      end else if (inst_valid) begin
        waited++;
      end
      r = take_bits(2);
      retire_ready = !stall_retire || r[1:0] != 2'b00;
      if (!inst_valid && sent < count) begin
        r = take_bits(3);
        if (r[2:0] != 3'b000) begin
          inst_valid = 1'b1;
          inst = '{pc: next_pc, inst: build_inst()};
          next_pc = next_pc + 32'd4;
        end
      end
      if (use_flush && sent < count) begin
        r = take_bits(4);
        flush = r[3:0] == 4'b0000;
      end
    end
    if (sent < count) begin
      other_errors++;
      $display("ERROR at %0t: instruction not accepted within %0d cycles",
               $time, accept_timeout);
      inst_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    inst_valid = 1'b0;
    flush = 1'b0;
    retire_ready = 1'b1;
    while (pending.size() != 0 && waited < drain_timeout) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (pending.size() != 0) begin
      other_errors++;
      $display("ERROR at %0t: %0d instructions never retired", $time, pending.size());
    end
  endtask

  task automatic compare_regs();
    logic [4:0] idx;
    for (int i = 1; i < 8; i++) begin
      idx = i[4:0];
      check_word($sformatf("x%0d", idx), dut0.u_reg_file.regs[idx], model_regs[idx]);
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("ERROR: simulation still running after %0d cycles", watchdog_cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    lfsr_state = 32'hdaeebee0;
    reset = 1'b1;
    flush = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    retire_ready = 1'b1;
    model_regs = '{default: '0};
    next_pc = 32'h0000_1000;
    cycle_count = '0;
    in_fire = 1'b0;
    timing_mode = 1'b0;
    retired = 0;
    mismatches = 0;
    other_errors = 0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    // decode stage is empty out of reset
    check_word("inst_ready", {31'd0, inst_ready}, 32'd1);
    // retire_ready held high, so the latency is exact
    timing_mode = 1'b1;
    issue_stream(40, 1'b0, 1'b0);
    drain();
    timing_mode = 1'b0;
    issue_stream(400, 1'b0, 1'b0);
    drain();
    issue_stream(300, 1'b1, 1'b0);
    drain();
    issue_stream(300, 1'b1, 1'b1);
    drain();
    compare_regs();
    assertion_failures = dut0.props0.failures;
    $display("result: %0d retired, %0d mismatches, %0d other errors, %0d assertion failures",
             retired, mismatches, other_errors, assertion_failures);
    if (mismatches == 0 && other_errors == 0 && assertion_failures == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
src/rv_pkg.sv
src/decode_ctrl.sv
src/imm_gen.sv
src/reg_file.sv
src/alu.sv
src/pipe_reg.sv
src/int_core.sv
tests/int_core_props.sv
tests/int_core_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module int_core_tb -f build.f
output=$(./obj_dir/Vint_core_tb +verilator+error+limit+1000 || true)
echo "$output"
if echo "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
